// File: list.f
design/TexturePkg.sv
design/TextureLoadControl.sv
design/WriteAddressCounter.sv
design/TextureRam.sv
design/TexelLocator.sv
design/TextureUnit.sv
tb/TextureUnitTb.sv

// File: Makefile
# Verilator build and run for the texture unit testbench

SIM       = verilator
TOP       = TextureUnitTb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
FLAGS     = --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP)

SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/TextureUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module TextureUnitTb;

    localparam int SHADOW_TEXELS = 8192;

    logic          clk = 1'b0;
    logic          reset;
    logic          streamValid;
    logic          streamLast;
    logic [31 : 0] streamData;
    logic          streamReady;
    logic [7 : 0]  textureSizeX;
    logic [7 : 0]  textureSizeY;
    logic [15 : 0] texelX;
    logic [15 : 0] texelY;
    logic [15 : 0] texel;
    logic          textureLoaded;

    integer seed;

    // Mirror of every texel written by the stream
    logic [15 : 0] shadow [SHADOW_TEXELS];

    // Expected values registered on the same edge as the DUT
    logic          checkFetch = 1'b0;
    logic          fetchArmed = 1'b0;
    logic [15 : 0] expectTexel = '0;
    logic          expectLoaded = 1'b0;
    logic          resetSeen = 1'b0;

    TextureUnit #(
        .SIZE_LOG2(14)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .streamValid(streamValid),
        .streamLast(streamLast),
        .streamData(streamData),
        .streamReady(streamReady),
        .textureSizeX(textureSizeX),
        .textureSizeY(textureSizeY),
        .texelX(texelX),
        .texelY(texelY),
        .texel(texel),
        .textureLoaded(textureLoaded)
    );

    always #50 clk = ~clk;

    task automatic stopOnMismatch(input string name, input logic [31 : 0] expected,
                                  input logic [31 : 0] actual);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic stopOnTimeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "Timeout");
    endtask

    // One more index bit than the position of the lowest set bit
    function automatic int axisBits(input logic [7 : 0] size);
        for (int k = 0; k < 8; k++)
        begin
            if (size[k])
            begin
                return k + 1;
            end
        end
        return 0;
    endfunction

    // Top bits of the 15-bit fraction
    function automatic logic [31 : 0] axisIndex(input logic [15 : 0] coord, input int bits);
        logic [31 : 0] fraction;
        fraction = {17'd0, coord[14 : 0]};
        return fraction >> (15 - bits);
    endfunction

    function automatic logic [15 : 0] referenceTexel(input logic [7 : 0] sizeX,
                                                     input logic [7 : 0] sizeY,
                                                     input logic [15 : 0] x,
                                                     input logic [15 : 0] y);
        int xb;
        logic [31 : 0] index;
        xb = axisBits(sizeX);
        index = (axisIndex(y, axisBits(sizeY)) << xb) | axisIndex(x, xb);
        return shadow[index[12 : 0]];
    endfunction

    always @(posedge clk)
    begin
        resetSeen <= reset;
        fetchArmed <= checkFetch;
        expectTexel <= referenceTexel(textureSizeX, textureSizeY, texelX, texelY);
        if (reset)
        begin
            expectLoaded <= 1'b0;
        end
        else if (streamValid && streamLast)
        begin
            expectLoaded <= 1'b1;
        end
        else if (streamValid)
        begin
            expectLoaded <= 1'b0;
        end
    end

    readyInReset: assert property (@(posedge clk) (reset && resetSeen) |-> !streamReady)
    else stopOnMismatch("streamReady", 32'd0, 32'($sampled(streamReady)));

    readyAfterReset: assert property (@(posedge clk) (!reset && !resetSeen) |-> streamReady)
    else stopOnMismatch("streamReady", 32'd1, 32'($sampled(streamReady)));

    loadedFlag: assert property (@(posedge clk) !reset |-> textureLoaded == expectLoaded)
    else stopOnMismatch("textureLoaded", 32'($sampled(expectLoaded)),
                        32'($sampled(textureLoaded)));

    fetchedTexel: assert property (@(posedge clk) fetchArmed |-> texel == expectTexel)
    else stopOnMismatch("texel", 32'($sampled(expectTexel)), 32'($sampled(texel)));

    task automatic waitForReady(input int limit);
        int cycles;
        cycles = 0;
        while (!streamReady)
        begin
            if (cycles == limit)
            begin
                stopOnTimeout("streamReady never rose after reset");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic waitForLoaded(input int limit);
        int cycles;
        cycles = 0;
        while (!textureLoaded)
        begin
            if (cycles == limit)
            begin
                stopOnTimeout("textureLoaded never rose after the last beat");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Beats fill words from zero with lane 0 in the low half
    task automatic uploadTexture(input int beats);
        logic [31 : 0] word;
        logic [12 : 0] slot;
        for (int i = 0; i < beats; i++)
        begin
            @(negedge clk);
            word = $random(seed);
            slot = 13'(2 * i);
            streamValid = 1'b1;
            streamLast = (i == beats - 1);
            streamData = word;
            shadow[slot] = word[15 : 0];
            shadow[slot + 13'd1] = word[31 : 16];
        end
        @(negedge clk);
        streamValid = 1'b0;
        streamLast = 1'b0;
        waitForLoaded(10);
    endtask

    task automatic fetchRandom(input logic [7 : 0] sizeX, input logic [7 : 0] sizeY,
                               input int count);
        logic [31 : 0] word;
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            word = $random(seed);
            textureSizeX = sizeX;
            textureSizeY = sizeY;
            texelX = word[15 : 0];
            texelY = word[31 : 16];
            checkFetch = 1'b1;
        end
        @(negedge clk);
        checkFetch = 1'b0;
    endtask

    // Even then odd column inside the same word of a 32 wide texture
    task automatic fetchLanes(input int words);
        logic [4 : 0] column;
        textureSizeX = 8'd16;
        textureSizeY = 8'd16;
        for (int w = 0; w < words; w++)
        begin
            column = {w[3 : 0], 1'b0};
            @(negedge clk);
            texelX = {1'b0, column, 10'd0};
            texelY = {1'b0, 5'(w + 3), 10'd0};
            checkFetch = 1'b1;
            @(negedge clk);
            texelX = {1'b0, column | 5'd1, 10'd0};
        end
        @(negedge clk);
        checkFetch = 1'b0;
    endtask

    initial
    begin
        seed = 32'hfc72;
        reset = 1'b1;
        streamValid = 1'b0;
        streamLast = 1'b0;
        streamData = '0;
        textureSizeX = '0;
        textureSizeY = '0;
        texelX = '0;
        texelY = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        waitForReady(10);

        // 32x32 texture followed by fetch, lane and size decoding checks
        uploadTexture(512);
        fetchRandom(8'd16, 8'd16, 200);
        fetchLanes(16);
        fetchRandom(8'd48, 8'd16, 50);
        fetchRandom(8'd0, 8'd0, 30);

        // 64x16 texture overwrites from word zero
        uploadTexture(512);
        fetchRandom(8'd32, 8'd8, 200);

        repeat (2) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/TextureUnit.sv
`timescale 1ns/100ps
`default_nettype none

module TextureUnit #(
    // RAM size in bytes, as a power of two, from 10 to 16
    parameter int SIZE_LOG2 = 14
)
(
    input  wire                                    clk,
    input  wire                                    reset,

    // Texture upload stream
    input  wire                                    streamValid,
    input  wire                                    streamLast,
    input  wire  [TexturePkg::STREAM_WIDTH - 1 : 0] streamData,
    output logic                                   streamReady,

    // Texel fetch
    input  wire  [7 : 0]                           textureSizeX,
    input  wire  [7 : 0]                           textureSizeY,
    input  wire  [15 : 0]                          texelX,
    input  wire  [15 : 0]                          texelY,
    output logic [TexturePkg::TEXEL_WIDTH - 1 : 0]  texel,
    output logic                                   textureLoaded
);
    import TexturePkg::*;

    localparam int ADDR_WIDTH = SIZE_LOG2 - $clog2(STREAM_WIDTH / 8);

    logic                      beatWrite;
    logic                      addressClear;
    logic [ADDR_WIDTH - 1 : 0] writeAddr;
    logic [ADDR_WIDTH - 1 : 0] readAddr;
    StreamWord                 readData;

    TextureLoadControl i_loadControl (
        .clk(clk),
        .reset(reset),
        .streamValid(streamValid),
        .streamLast(streamLast),
        .streamReady(streamReady),
        .beatWrite(beatWrite),
        .addressClear(addressClear),
        .textureLoaded(textureLoaded)
    );

    WriteAddressCounter #(
        .SIZE_LOG2(SIZE_LOG2)
    ) i_writeAddressCounter (
        .clk(clk),
        .reset(reset),
        .beatWrite(beatWrite),
        .addressClear(addressClear),
        .writeAddr(writeAddr)
    );

    // Stream beats go in as raw words
    TextureRam #(
        .SIZE_LOG2(SIZE_LOG2)
    ) i_textureRam (
        .clk(clk),
        .writeEnable(beatWrite),
        .writeAddr(writeAddr),
        .writeData(streamData),
        .readAddr(readAddr),
        .readData(readData)
    );

    TexelLocator #(
        .SIZE_LOG2(SIZE_LOG2)
    ) i_texelLocator (
        .clk(clk),
        .textureSizeX(textureSizeX),
        .textureSizeY(textureSizeY),
        .texelX(texelX),
        .texelY(texelY),
        .readAddr(readAddr),
        .readData(readData),
        .texel(texel)
    );

endmodule

`default_nettype wire

// File: design/TexelLocator.sv
`timescale 1ns/100ps
`default_nettype none

module TexelLocator #(
    // RAM size in bytes, as a power of two
    parameter int SIZE_LOG2 = 14,
    localparam int ADDR_WIDTH = SIZE_LOG2 - $clog2(TexturePkg::STREAM_WIDTH / 8)
)
(
    input  wire                                  clk,

    // Texture sizes, lowest set bit gives the extent
    input  wire  [7 : 0]                         textureSizeX,
    input  wire  [7 : 0]                         textureSizeY,

    // Fixed-point coordinates, fraction in bits 14 down to 0
    input  wire  [15 : 0]                        texelX,
    input  wire  [15 : 0]                        texelY,

    // RAM read port
    output logic [ADDR_WIDTH - 1 : 0]            readAddr,
    input  wire  TexturePkg::StreamWord          readData,

    output logic [TexturePkg::TEXEL_WIDTH - 1 : 0] texel
);
    import TexturePkg::*;

    logic [3 : 0]  xBits;
    logic [3 : 0]  yBits;
    logic [7 : 0]  xIndex;
    logic [7 : 0]  yIndex;
    logic [15 : 0] texelIndex;

    // Lane of the fetch whose word is coming back from the RAM
    logic [LANE_BITS - 1 : 0] laneDelay;

    // Index bits of one axis, from the lowest set bit of its size byte
    function automatic logic [3 : 0] indexBits(input logic [7 : 0] size);
        logic [3 : 0] bits;
        casez (size)
            8'b???????1: bits = 4'd1;
            8'b??????10: bits = 4'd2;
            8'b?????100: bits = 4'd3;
            8'b????1000: bits = 4'd4;
            8'b???10000: bits = 4'd5;
            8'b??100000: bits = 4'd6;
            8'b?1000000: bits = 4'd7;
            8'b10000000: bits = 4'd8;
            default:     bits = 4'd0;
        endcase
        return bits;
    endfunction

    // Coordinate field of the given width, taken right below bit 15
    function automatic logic [7 : 0] coordField(
        input logic [15 : 0] coord,
        input logic [3 : 0]  bits
    );
        logic [7 : 0] top;
        top = coord[14 : 7];
        return top >> (4'd8 - bits);
    endfunction

    always_comb
    begin
        xBits = indexBits(textureSizeX);
        yBits = indexBits(textureSizeY);
        xIndex = coordField(texelX, xBits);
        yIndex = coordField(texelY, yBits);

        // Row index sits directly above the column index
        texelIndex = ({8'h00, yIndex} << xBits) | {8'h00, xIndex};
    end

    // Drop the lane bit, keep what fits the RAM
    assign readAddr = texelIndex[LANE_BITS +: ADDR_WIDTH];

    // Matches the RAM read latency
    always_ff @(posedge clk)
    begin
        laneDelay <= texelIndex[LANE_BITS - 1 : 0];
    end

    assign texel = readData.texels[laneDelay];

endmodule

`default_nettype wire

// File: design/TextureRam.sv
`timescale 1ns/100ps
`default_nettype none

module TextureRam #(
    // RAM size in bytes, as a power of two
    parameter int SIZE_LOG2 = 14,
    localparam int ADDR_WIDTH = SIZE_LOG2 - $clog2(TexturePkg::STREAM_WIDTH / 8)
)
(
    input  wire                        clk,

    // Write port
    input  wire                        writeEnable,
    input  wire  [ADDR_WIDTH - 1 : 0]  writeAddr,
    input  wire  TexturePkg::StreamWord writeData,

    // Registered read port
    input  wire  [ADDR_WIDTH - 1 : 0]  readAddr,
    output TexturePkg::StreamWord      readData
);
    import TexturePkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    StreamWord mem [DEPTH];

    // One enable per texel lane, all set for a full-word write
    logic [TEXELS_PER_WORD - 1 : 0] laneWrite;

    assign laneWrite = {TEXELS_PER_WORD{writeEnable}};

    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < TEXELS_PER_WORD; lane++)
        begin
            if (laneWrite[lane])
            begin
                mem[writeAddr].raw[lane * TEXEL_WIDTH +: TEXEL_WIDTH] <=
                    writeData.raw[lane * TEXEL_WIDTH +: TEXEL_WIDTH];
            end
        end
    end

    // One cycle read latency
    always_ff @(posedge clk)
    begin
        readData <= mem[readAddr];
    end

endmodule

`default_nettype wire

// File: design/WriteAddressCounter.sv
`timescale 1ns/100ps
`default_nettype none

module WriteAddressCounter #(
    // RAM size in bytes, as a power of two
    parameter int SIZE_LOG2 = 14,
    localparam int ADDR_WIDTH = SIZE_LOG2 - $clog2(TexturePkg::STREAM_WIDTH / 8)
)
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        beatWrite,
    input  wire                        addressClear,
    output logic [ADDR_WIDTH - 1 : 0]  writeAddr
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            writeAddr <= '0;
        end
        else if (addressClear)
        begin
            // Next upload starts again at word zero
            writeAddr <= '0;
        end
        else if (beatWrite)
        begin
            // Wraps at the top of the RAM
            writeAddr <= writeAddr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/TextureLoadControl.sv
`timescale 1ns/100ps
`default_nettype none

module TextureLoadControl
(
    input  wire  clk,
    input  wire  reset,

    // Upload stream
    input  wire  streamValid,
    input  wire  streamLast,
    output logic streamReady,

    // Steering for the write address counter
    output logic beatWrite,
    output logic addressClear,

    output logic textureLoaded
);
    import TexturePkg::*;

    LoadState state;
    LoadState nextState;

    // Every valid beat is taken once the unit is out of reset
    assign beatWrite = streamValid && streamReady;

    // The final beat also returns the counter to word zero
    assign addressClear = beatWrite && streamLast;

    always_comb
    begin
        nextState = state;
        if (addressClear)
        begin
            // Covers a single-beat texture too
            nextState = Loaded;
        end
        else if (beatWrite)
        begin
            nextState = Loading;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= Idle;
            streamReady <= 1'b0;
        end
        else
        begin
            state <= nextState;
            streamReady <= 1'b1;
        end
    end

    assign textureLoaded = (state == Loaded);

endmodule

`default_nettype wire

// File: design/TexturePkg.sv
`default_nettype none

package TexturePkg;

    // One RGBA4444 texel
    localparam int TEXEL_WIDTH = 16;

    // One stream beat, also one RAM word
    localparam int STREAM_WIDTH = 32;

    localparam int TEXELS_PER_WORD = STREAM_WIDTH / TEXEL_WIDTH;

    // Selects a texel inside a word
    localparam int LANE_BITS = $clog2(TEXELS_PER_WORD);

    // The stream writes raw bits, the fetch side reads texels
    // Lane 0 sits in the low half of the word
    typedef union packed
    {
        logic [STREAM_WIDTH - 1 : 0] raw;
        logic [TEXELS_PER_WORD - 1 : 0][TEXEL_WIDTH - 1 : 0] texels;
    } StreamWord;

    // Upload progress
    typedef enum logic [1 : 0]
    {
        Idle,
        Loading,
        Loaded
    } LoadState;

endpackage

`default_nettype wire
